//--- src/pci_defines.svh
`ifndef PCI_DEFINES_SVH
`define PCI_DEFINES_SVH

// Bus geometry shared by the bridges, the interface and the RAM

// Byte address carried on adr
`define PCI_ADDR_W    32

// Width of dat_w and dat_r
`define PCI_DATA_W    32

// One strobe per byte lane
`define PCI_BE_W      4

// Depth of the shared RAM in words
`define PCI_RAM_WORDS 256

`endif

//--- src/pci_pkg.sv
`include "pci_defines.svh"

package pci_pkg;

    // Byte address as seen by the core and on the bus
    typedef logic [`PCI_ADDR_W-1:0] addr_t;

    // Instruction or data word
    typedef logic [`PCI_DATA_W-1:0] word_t;

    // Byte strobes, bit i covers bits 8*i+7 down to 8*i
    typedef logic [`PCI_BE_W-1:0]   be_t;

    // Word index into the shared RAM
    typedef logic [$clog2(`PCI_RAM_WORDS)-1:0] ram_idx_t;

    // Bridge FSM
    // ST_IDLE  waiting for a core request
    // ST_BUS   Wishbone cycle open, waiting for ack
    // ST_DONE  result captured, valid pulses next
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BUS,
        ST_DONE
    } bridge_state_e;

endpackage

//--- src/wb_if.sv
`include "pci_defines.svh"

// Wishbone classic bus between one master and one slave
interface wb_if import pci_pkg::*; ();

    logic  cyc;   // Cycle in progress
    logic  stb;   // Strobe, valid transfer
    logic  we;    // 1 = write, 0 = read
    be_t   sel;   // Byte lane select
    addr_t adr;   // Byte address
    word_t dat_w; // Master to slave data
    word_t dat_r; // Slave to master data
    logic  ack;   // One cycle per transfer

    modport master (
        output cyc,
        output stb,
        output we,
        output sel,
        output adr,
        output dat_w,
        input  dat_r,
        input  ack
    );

    modport slave (
        input  cyc,
        input  stb,
        input  we,
        input  sel,
        input  adr,
        input  dat_w,
        output dat_r,
        output ack
    );

endinterface

//--- src/fetch_bridge.sv
`include "pci_defines.svh"

module fetch_bridge import pci_pkg::*; (
    input  logic  clk,
    input  logic  rst_n_i,

    input  logic  req_i,   // Fetch request
    input  addr_t addr_i,  // Fetch address
    output logic  ready_o,
    output logic  valid_o, // One cycle with instr_o
    output word_t instr_o,

    wb_if.master  wb
);

    bridge_state_e state;
    addr_t         addr_q;
    logic          accept;

    assign ready_o = (state == ST_IDLE) && !valid_o; // Low until valid has pulsed
    assign accept  = req_i && ready_o;

    // Read-only master, all lanes
    assign wb.cyc   = (state == ST_BUS);
    assign wb.stb   = (state == ST_BUS);
    assign wb.we    = 1'b0;
    assign wb.sel   = {`PCI_BE_W{1'b1}};
    assign wb.adr   = addr_q;
    assign wb.dat_w = '0;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state   <= ST_IDLE;
            valid_o <= 1'b0;
        end else begin
            valid_o <= (state == ST_DONE);
            case (state)
                ST_IDLE: if (accept) state <= ST_BUS;
                ST_BUS:  if (wb.ack) state <= ST_DONE; // Drop cyc on ack edge
                ST_DONE: state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= addr_i;
        end
        if ((state == ST_BUS) && wb.ack) begin
            instr_o <= wb.dat_r; // Held until the next fetch completes
        end
    end

endmodule

//--- src/data_bridge.sv
`include "pci_defines.svh"

module data_bridge import pci_pkg::*; (
    input  logic  clk,
    input  logic  rst_n_i,

    input  logic  rd_en_i,
    input  logic  wr_en_i,
    input  addr_t addr_i,
    input  word_t wdata_i,
    input  be_t   be_i,    // Write strobes
    output logic  ready_o,
    output logic  valid_o, // Pulses for reads and writes
    output word_t rdata_o, // Don't-care after a write

    wb_if.master  wb
);

    bridge_state_e state;
    logic          accept;
    logic          we_q;
    addr_t         addr_q;
    word_t         wdata_q;
    be_t           sel_q;

    assign ready_o = (state == ST_IDLE) && !valid_o;
    assign accept  = (rd_en_i || wr_en_i) && ready_o;

    assign wb.cyc   = (state == ST_BUS);
    assign wb.stb   = (state == ST_BUS);
    assign wb.we    = we_q;
    assign wb.sel   = sel_q;
    assign wb.adr   = addr_q;
    assign wb.dat_w = wdata_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state   <= ST_IDLE;
            valid_o <= 1'b0;
        end else begin
            valid_o <= (state == ST_DONE);
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        state <= ST_BUS;
                    end
                end
                ST_BUS: begin
                    if (wb.ack) begin
                        state <= ST_DONE;
                    end
                end
                ST_DONE: state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Request latch and read capture
    always_ff @(posedge clk) begin
        if (accept) begin
            we_q    <= wr_en_i;                             // Both enables high means write
            addr_q  <= addr_i;
            wdata_q <= wdata_i;
            sel_q   <= wr_en_i ? be_i : {`PCI_BE_W{1'b1}}; // Reads fetch the whole word
        end
        if ((state == ST_BUS) && wb.ack) begin
            rdata_o <= wb.dat_r;
        end
    end

endmodule

//--- src/wb_arbiter.sv
// Two Wishbone masters onto one slave, round-robin on cyc
module wb_arbiter import pci_pkg::*; (
    input logic clk,
    input logic rst_n_i,

    wb_if.slave  m0, // Fetch bridge
    wb_if.slave  m1, // Data bridge
    wb_if.master s   // Toward the RAM
);

    logic locked;  // Bus held by owner
    logic owner;   // 0 = m0, 1 = m1
    logic last;    // Master served most recently
    logic grant;
    logic own_cyc;

    // Free bus grants at once so an uncontended master sees no extra cycle
    always_comb begin
        if (locked) begin
            grant = owner;
        end else if (m0.cyc && m1.cyc) begin
            grant = ~last; // Tie goes to the one not served last
        end else begin
            grant = m1.cyc;
        end
    end

    assign own_cyc = grant ? m1.cyc : m0.cyc;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            locked <= 1'b0;
            owner  <= 1'b0;
            last   <= 1'b1; // m0 wins the first tie
        end else if (locked) begin
            // Owner drops cyc on the edge it samples ack
            if (s.ack || !own_cyc) begin
                locked <= 1'b0;
                last   <= owner;
            end
        end else if (m0.cyc || m1.cyc) begin
            locked <= 1'b1;
            owner  <= grant;
        end
    end

    // Owner to slave
    always_comb begin
        if (grant) begin
            s.cyc   = m1.cyc;
            s.stb   = m1.stb;
            s.we    = m1.we;
            s.sel   = m1.sel;
            s.adr   = m1.adr;
            s.dat_w = m1.dat_w;
        end else begin
            s.cyc   = m0.cyc;
            s.stb   = m0.stb;
            s.we    = m0.we;
            s.sel   = m0.sel;
            s.adr   = m0.adr;
            s.dat_w = m0.dat_w;
        end
    end

    // Read data is shared, ack goes only to the owner
    assign m0.dat_r = s.dat_r;
    assign m1.dat_r = s.dat_r;
    assign m0.ack   = s.ack && !grant;
    assign m1.ack   = s.ack && grant;

endmodule

//--- src/shared_ram.sv
`include "pci_defines.svh"

// Word-addressed RAM behind a Wishbone classic slave port
module shared_ram import pci_pkg::*; (
    input logic clk,
    input logic rst_n_i,

    wb_if.slave wb
);

    word_t    mem [`PCI_RAM_WORDS];
    ram_idx_t idx;
    logic     req;

    // Word index from adr bits above the byte offset, higher bits wrap
    assign idx = ram_idx_t'(wb.adr[$bits(ram_idx_t)+1:2]);

    // New transfer, not the one being acked
    assign req = wb.cyc && wb.stb && !wb.ack;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wb.ack <= 1'b0;
        end else begin
            wb.ack <= req; // Single-cycle ack
        end
    end

    // Read data registered alongside ack
    always_ff @(posedge clk) begin
        if (req) begin
            wb.dat_r <= mem[idx];
        end
    end

    always_ff @(posedge clk) begin
        if (req && wb.we) begin
            for (int i = 0; i < `PCI_BE_W; i++) begin
                if (wb.sel[i]) begin
                    mem[idx][8*i +: 8] <= wb.dat_w[8*i +: 8]; // Lane i only
                end
            end
        end
    end

endmodule

//--- src/pci_mem_top.sv
// Fetch and data ports of a core sharing one RAM over Wishbone
module pci_mem_top import pci_pkg::*; (
    input  logic  clk,
    input  logic  rst_n_i,

    // Instruction fetch port
    input  logic  fetch_req_i,
    input  addr_t fetch_addr_i,
    output logic  fetch_ready_o,
    output logic  fetch_valid_o,
    output word_t fetch_instr_o,

    // Data port
    input  logic  data_rd_en_i,
    input  logic  data_wr_en_i,
    input  addr_t data_addr_i,
    input  word_t data_wdata_i,
    input  be_t   data_be_i,
    output logic  data_ready_o,
    output logic  data_valid_o,
    output word_t data_rdata_o
);

    wb_if fetch_bus ();
    wb_if data_bus ();
    wb_if ram_bus ();

    fetch_bridge u_fetch_bridge (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .req_i   (fetch_req_i),
        .addr_i  (fetch_addr_i),
        .ready_o (fetch_ready_o),
        .valid_o (fetch_valid_o),
        .instr_o (fetch_instr_o),
        .wb      (fetch_bus.master)
    );

    data_bridge u_data_bridge (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .rd_en_i (data_rd_en_i),
        .wr_en_i (data_wr_en_i),
        .addr_i  (data_addr_i),
        .wdata_i (data_wdata_i),
        .be_i    (data_be_i),
        .ready_o (data_ready_o),
        .valid_o (data_valid_o),
        .rdata_o (data_rdata_o),
        .wb      (data_bus.master)
    );

    wb_arbiter u_wb_arbiter (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .m0      (fetch_bus.slave), // Fetch
        .m1      (data_bus.slave),  // Data
        .s       (ram_bus.master)
    );

    shared_ram u_shared_ram (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .wb      (ram_bus.slave)
    );

endmodule

//--- dv/clk_gen.sv
// Testbench clock and synchronous reset source
module clk_gen (
    output logic clk_o,
    output logic rst_n_o
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk_o   = 1'b0;
        rst_n_o = 1'b0;
        forever #2 clk_o = ~clk_o; // 4 ns period
    end

    initial begin
        repeat (10) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end
endmodule

//--- dv/pci_sva.sv
// Protocol checks on the arbiter's three buses
module pci_sva (
    input logic clk,
    input logic rst_n_i,
    input logic m0_cyc,
    input logic m0_stb,
    input logic m0_ack,
    input logic m1_cyc,
    input logic m1_stb,
    input logic m1_ack,
    input logic s_cyc,
    input logic s_stb,
    input logic s_ack
);
    timeunit 1ns;
    timeprecision 100ps;

    int unsigned err_count = 0; // Failed assertions so far

    // Slave ack reaches exactly one master, the one holding cyc
    a_ack_owner: assert property (@(posedge clk) disable iff (!rst_n_i)
        s_ack |-> $onehot({m0_ack && m0_cyc, m1_ack && m1_cyc}))
    else begin
        err_count++;
        $error("ack not returned to exactly one active master");
    end

    // One ack per transfer
    a_ack_single: assert property (@(posedge clk) disable iff (!rst_n_i)
        s_ack |=> !s_ack)
    else begin
        err_count++;
        $error("slave ack high for two cycles");
    end

    a_stb_m0: assert property (@(posedge clk) disable iff (!rst_n_i)
        m0_stb |-> m0_cyc)
    else begin
        err_count++;
        $error("m0 stb without cyc");
    end

    a_stb_m1: assert property (@(posedge clk) disable iff (!rst_n_i)
        m1_stb |-> m1_cyc)
    else begin
        err_count++;
        $error("m1 stb without cyc");
    end

    a_stb_s: assert property (@(posedge clk) disable iff (!rst_n_i)
        s_stb |-> s_cyc)
    else begin
        err_count++;
        $error("slave stb without cyc");
    end
endmodule

bind wb_arbiter pci_sva u_pci_sva (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .m0_cyc  (m0.cyc),
    .m0_stb  (m0.stb),
    .m0_ack  (m0.ack),
    .m1_cyc  (m1.cyc),
    .m1_stb  (m1.stb),
    .m1_ack  (m1.ack),
    .s_cyc   (s.cyc),
    .s_stb   (s.stb),
    .s_ack   (s.ack)
);

//--- dv/tb_top.sv
module tb_top import pci_pkg::*; ;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_TESTS = 6;

    logic  clk, rst_n_i;
    logic  fetch_req_i, fetch_ready_o, fetch_valid_o;
    addr_t fetch_addr_i;
    word_t fetch_instr_o;
    logic  data_rd_en_i, data_wr_en_i, data_ready_o, data_valid_o;
    addr_t data_addr_i;
    word_t data_wdata_i, data_rdata_o;
    be_t   data_be_i;

    word_t  ref_mem [256]; // Reference RAM model
    integer seed = 32'hee18c528;

    clk_gen u_clk_gen (.clk_o(clk), .rst_n_o(rst_n_i));

    pci_mem_top DUT (.*);

    initial begin // Watchdog
        repeat (NUM_TESTS * 400) @(posedge clk);
        $display("timeout, the tests did not finish in time");
        $display("RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

    initial begin // Protocol assertion monitor
        wait (DUT.u_wb_arbiter.u_pci_sva.err_count != 0);
        $display("a Wishbone protocol assertion failed");
        $display("RESULT: FAIL");
        $fatal(1, "assertion failed");
    end

    task automatic report_mismatch(input string name, input word_t got, input word_t exp);
        $display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
        $display("RESULT: FAIL");
        $fatal(1, "check failed");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) report_mismatch(name, got, exp);
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) report_mismatch(name, word_t'(got), word_t'(exp));
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) report_mismatch(name, word_t'(got), word_t'(exp));
    endtask

    function automatic int word_idx(input addr_t addr);
        return int'(addr[9:2]); // Upper bits wrap
    endfunction

    task automatic model_write(input addr_t addr, input word_t wdata, input be_t be);
        for (int i = 0; i < 4; i++) begin
            if (be[i]) ref_mem[word_idx(addr)][8*i +: 8] = wdata[8*i +: 8];
        end
    endtask

    task automatic data_access(input logic wr, input addr_t addr, input word_t wdata,
                               input be_t be, output word_t rdata, output int lat);
        @(posedge clk);
        data_rd_en_i <= !wr;
        data_wr_en_i <= wr;
        data_addr_i  <= addr;
        data_wdata_i <= wdata;
        data_be_i    <= be;
        do @(negedge clk); while (!data_ready_o);
        @(posedge clk); // Accept edge
        data_rd_en_i <= 1'b0;
        data_wr_en_i <= 1'b0;
        lat = 0;
        do begin
            @(posedge clk);
            lat++;
            @(negedge clk);
        end while (!data_valid_o);
        rdata = data_rdata_o;
    endtask

    task automatic do_write(input addr_t addr, input word_t wdata, input be_t be,
                            output int lat);
        word_t unused;
        data_access(1'b1, addr, wdata, be, unused, lat);
        model_write(addr, wdata, be);
    endtask

    task automatic do_read(input addr_t addr, output int lat);
        word_t rdata;
        data_access(1'b0, addr, '0, '0, rdata, lat);
        check_word("data_rdata_o", rdata, ref_mem[word_idx(addr)]);
    endtask

    task automatic do_fetch(input addr_t addr, output int lat);
        @(posedge clk);
        fetch_req_i  <= 1'b1;
        fetch_addr_i <= addr;
        do @(negedge clk); while (!fetch_ready_o);
        @(posedge clk);
        fetch_req_i <= 1'b0;
        lat = 0;
        do begin
            @(posedge clk);
            lat++;
            @(negedge clk);
            if (lat == 1) check_addr("fetch_bus.adr", DUT.fetch_bus.adr, addr);
        end while (!fetch_valid_o);
        check_word("fetch_instr_o", fetch_instr_o, ref_mem[word_idx(addr)]);
    endtask

    task automatic test_reset_single();
        int lat;
        @(negedge clk);
        check_flag("fetch_ready_o", fetch_ready_o, 1'b1);
        check_flag("data_ready_o", data_ready_o, 1'b1);
        check_flag("fetch_valid_o", fetch_valid_o, 1'b0);
        check_flag("data_valid_o", data_valid_o, 1'b0);
        do_write(32'h10, 32'hdeadbeef, 4'hf, lat);
        check_flag("write latency is 3", lat == 3, 1'b1);
        do_read(32'h10, lat);
        check_flag("read latency is 3", lat == 3, 1'b1);
        do_fetch(32'h10, lat);
        check_flag("fetch latency is 3", lat == 3, 1'b1);
    endtask

    task automatic test_byte_strobes();
        int    lat;
        word_t rdata;
        do_write(32'h20, 32'h11223344, 4'hf, lat);
        do_write(32'h20, 32'h000000aa, 4'b0001, lat);
        do_write(32'h20, 32'hbbcc0000, 4'b1100, lat);
        data_access(1'b0, 32'h20, '0, '0, rdata, lat);
        check_word("data_rdata_o", rdata, 32'hbbcc33aa); // Lane 1 from the first write
        do_write(32'h24, 32'h55667788, 4'b0110, lat);
        do_read(32'h24, lat);
    endtask

    task automatic test_shared_memory();
        int lat;
        for (int i = 0; i < 4; i++) begin
            do_write(addr_t'(32'h40 + 4 * i), $random(seed), 4'hf, lat);
            do_fetch(addr_t'(32'h40 + 4 * i), lat);
        end
        do_write(32'h0000_1048, 32'hcafef00d, 4'hf, lat); // Wraps onto word 18
        do_fetch(32'h48, lat);
        do_fetch(32'h0000_3048, lat);
    endtask

    task automatic test_contention();
        int lat_f, lat_d;
        for (int i = 0; i < 6; i++) begin
            fork
                do_fetch(addr_t'(32'h40 + 4 * (i % 4)), lat_f);
                if (i[0]) do_read(32'h10, lat_d);
                else do_write(addr_t'(32'h80 + 4 * i), $random(seed), 4'hf, lat_d);
            join
            check_flag("fetch wait within 7", lat_f <= 7, 1'b1);
            check_flag("data wait within 7", lat_d <= 7, 1'b1);
        end
    endtask

    task automatic test_back_pressure();
        int lat, pulses;
        do_write(32'h50, 32'ha5a5a5a5, 4'hf, lat);
        do_write(32'h54, 32'h5a5a5a5a, 4'hf, lat);
        pulses = 0;
        @(posedge clk);
        data_rd_en_i <= 1'b1;
        data_addr_i  <= 32'h50;
        do @(negedge clk); while (!data_ready_o);
        @(posedge clk);
        data_addr_i <= 32'h54; // Second request held while ready is low
        do @(negedge clk); while (!data_valid_o);
        pulses++;
        check_word("data_rdata_o", data_rdata_o, ref_mem[word_idx(32'h50)]);
        @(posedge clk);
        data_rd_en_i <= 1'b0;
        repeat (8) begin
            @(negedge clk);
            if (data_valid_o) pulses++;
        end
        check_flag("single valid pulse", pulses == 1, 1'b1);
    endtask

    task automatic test_random_mix();
        int    lat_f, lat_d, op;
        addr_t a_f, a_d;
        for (int i = 0; i < 16; i++) do_write(addr_t'(4 * i), $random(seed), 4'hf, lat_d);
        for (int i = 0; i < 64; i++) begin
            op  = $random(seed) & 3;
            a_f = {$random(seed)} & 32'h0000_f03c; // Words 0..15 with wrap bits
            a_d = {$random(seed)} & 32'h0000_f03c;
            case (op)
                0: do_fetch(a_f, lat_f);
                1: do_read(a_d, lat_d);
                2: do_write(a_d, $random(seed), be_t'($random(seed)), lat_d);
                default: fork
                    do_fetch(a_f, lat_f);
                    do_read(a_d, lat_d);
                join
            endcase
        end
    endtask

    initial begin
        fetch_req_i  = 1'b0;
        fetch_addr_i = '0;
        data_rd_en_i = 1'b0;
        data_wr_en_i = 1'b0;
        data_addr_i  = '0;
        data_wdata_i = '0;
        data_be_i    = '0;
        wait (rst_n_i === 1'b1);
        test_reset_single();
        test_byte_strobes();
        test_shared_memory();
        test_contention();
        test_back_pressure();
        test_random_mix();
        $display("RESULT: PASS");
        $finish;
    end
endmodule

//--- build.f
+incdir+src
src/pci_pkg.sv
src/wb_if.sv
src/fetch_bridge.sv
src/data_bridge.sv
src/wb_arbiter.sv
src/shared_ram.sv
src/pci_mem_top.sv
dv/clk_gen.sv
dv/pci_sva.sv
dv/tb_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST) | grep -v '^+')
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
